/* hw/apu_cfg.svh */
`ifndef APU_CFG_SVH
`define APU_CFG_SVH

// output sample and channel level widths
`define APU_SAMPLE_W 16
`define APU_VOL_W 4

`define APU_FREQ_W 11
`define APU_NUM_CH 3
`define APU_NUM_REGS 8

// tick_256 pulses per envelope step
`define APU_ENV_DIV 4
`define APU_MIX_SHIFT 6

`endif

/* hw/apu_pkg.sv */
package apu_pkg;

    // 3-bit register index
    typedef enum logic [2:0] {
        REG_SQ1_CTL    = 3'd0,
        REG_SQ1_FREQ   = 3'd1,
        REG_SQ2_CTL    = 3'd2,
        REG_SQ2_FREQ   = 3'd3,
        REG_NOISE_CTL  = 3'd4,
        REG_NOISE_FREQ = 3'd5,
        REG_MASTER     = 3'd6,
        REG_POWER      = 3'd7
    } apu_reg_e;

    // envelope step direction
    typedef enum logic {
        ENV_DOWN = 1'b0,
        ENV_UP   = 1'b1
    } env_dir_e;

endpackage

/* hw/chan_ctl_if.sv */
`timescale 1ns/1ps
`include "apu_cfg.svh"

interface chan_ctl_if;
    import apu_pkg::*;

    logic [1:0]            duty;
    logic [5:0]            length;
    logic [`APU_VOL_W-1:0] init_vol;
    env_dir_e              env_dir;
    logic [2:0]            env_period;
    // noise fields share this one
    logic [`APU_FREQ_W-1:0] freq;
    logic                  len_en;
    logic                  trigger;
    logic                  active;

    modport ctl (output duty, length, init_vol, env_dir, env_period, freq, len_en, trigger);

    modport chan (input duty, length, init_vol, env_dir, env_period, freq, len_en, trigger,
                  output active);

endinterface

/* hw/apu_control.sv */
`timescale 1ns/1ps
`include "apu_cfg.svh"

module apu_control (
    input  logic              clk_100,
    input  logic              reset,
    input  logic              reg_we,
    input  apu_pkg::apu_reg_e reg_addr,
    input  logic [15:0]       reg_wdata,
    input  logic              tick_256,
    chan_ctl_if.ctl           sq1,
    chan_ctl_if.ctl           sq2,
    chan_ctl_if.ctl           nz,
    output logic              power_on,
    output logic              length_clk,
    output logic              env_clk,
    output logic [2:0]        pan_l,
    output logic [2:0]        pan_r,
    output logic [2:0]        vol_l,
    output logic [2:0]        vol_r
);
    import apu_pkg::*;

    localparam int DIV_W = $clog2(`APU_ENV_DIV);

    logic [15:0]      regs [`APU_NUM_REGS];
    logic             wr_ok;
    logic             is_freq;
    logic [2:0]       trig_pend;
    logic [DIV_W-1:0] div_cnt;

    assign power_on = regs[REG_POWER][7];
    // only POWER is writable while powered down
    assign wr_ok    = reg_we && (power_on || reg_addr == REG_POWER);
    assign is_freq  = reg_addr inside {REG_SQ1_FREQ, REG_SQ2_FREQ, REG_NOISE_FREQ};

    always_ff @(posedge clk_100) begin
        if (reset) begin
            for (int i = 0; i < `APU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            trig_pend <= '0;
        end else begin
            if (!power_on) begin
                for (int i = 0; i < `APU_NUM_REGS; i++) begin
                    if (i != int'(REG_POWER)) begin
                        regs[i] <= '0;
                    end
                end
            end
            if (wr_ok) begin
                // trigger bit is never stored
                regs[reg_addr] <= is_freq ? {1'b0, reg_wdata[14:0]} : reg_wdata;
            end
            trig_pend[0] <= wr_ok && reg_addr == REG_SQ1_FREQ && reg_wdata[15];
            trig_pend[1] <= wr_ok && reg_addr == REG_SQ2_FREQ && reg_wdata[15];
            trig_pend[2] <= wr_ok && reg_addr == REG_NOISE_FREQ && reg_wdata[15];
        end
    end

    // trigger pulses and frame sequencer strobes
    always_ff @(posedge clk_100) begin
        if (reset) begin
            sq1.trigger <= 1'b0;
            sq2.trigger <= 1'b0;
            nz.trigger  <= 1'b0;
            length_clk  <= 1'b0;
            env_clk     <= 1'b0;
            div_cnt     <= '0;
        end else begin
            sq1.trigger <= trig_pend[0];
            sq2.trigger <= trig_pend[1];
            nz.trigger  <= trig_pend[2];
            length_clk  <= tick_256;
            env_clk     <= tick_256 && div_cnt == DIV_W'(`APU_ENV_DIV - 1);
            if (tick_256) begin
                div_cnt <= (div_cnt == DIV_W'(`APU_ENV_DIV - 1)) ? '0 : div_cnt + 1'b1;
            end
        end
    end

    assign sq1.duty       = regs[REG_SQ1_CTL][15:14];
    assign sq1.length     = regs[REG_SQ1_CTL][13:8];
    assign sq1.init_vol   = regs[REG_SQ1_CTL][7:4];
    assign sq1.env_dir    = env_dir_e'(regs[REG_SQ1_CTL][3]);
    assign sq1.env_period = regs[REG_SQ1_CTL][2:0];
    assign sq1.freq       = regs[REG_SQ1_FREQ][`APU_FREQ_W-1:0];
    assign sq1.len_en     = regs[REG_SQ1_FREQ][14];

    assign sq2.duty       = regs[REG_SQ2_CTL][15:14];
    assign sq2.length     = regs[REG_SQ2_CTL][13:8];
    assign sq2.init_vol   = regs[REG_SQ2_CTL][7:4];
    assign sq2.env_dir    = env_dir_e'(regs[REG_SQ2_CTL][3]);
    assign sq2.env_period = regs[REG_SQ2_CTL][2:0];
    assign sq2.freq       = regs[REG_SQ2_FREQ][`APU_FREQ_W-1:0];
    assign sq2.len_en     = regs[REG_SQ2_FREQ][14];

    assign nz.duty        = regs[REG_NOISE_CTL][15:14];
    assign nz.length      = regs[REG_NOISE_CTL][13:8];
    assign nz.init_vol    = regs[REG_NOISE_CTL][7:4];
    assign nz.env_dir     = env_dir_e'(regs[REG_NOISE_CTL][3]);
    assign nz.env_period  = regs[REG_NOISE_CTL][2:0];
    assign nz.freq        = regs[REG_NOISE_FREQ][`APU_FREQ_W-1:0];
    assign nz.len_en      = regs[REG_NOISE_FREQ][14];

    assign pan_r = regs[REG_MASTER][2:0];
    assign pan_l = regs[REG_MASTER][6:4];
    assign vol_r = regs[REG_MASTER][10:8];
    assign vol_l = regs[REG_MASTER][14:12];

    a_one_trigger: assert property (@(posedge clk_100) disable iff (reset)
        $onehot0({sq1.trigger, sq2.trigger, nz.trigger}));

endmodule

/* hw/tone_channel.sv */
`timescale 1ns/1ps
`include "apu_cfg.svh"

module tone_channel (
    input  logic                  clk_100,
    input  logic                  reset,
    input  logic                  tick_psg,
    input  logic                  length_clk,
    input  logic                  env_clk,
    chan_ctl_if.chan              ctl,
    output logic [`APU_VOL_W-1:0] level
);
    import apu_pkg::*;

    logic [`APU_FREQ_W-1:0] timer;
    logic [`APU_FREQ_W-1:0] reload;
    logic [2:0]             step;
    logic [7:0]             pattern;
    logic [6:0]             len_cnt;
    logic [`APU_VOL_W-1:0]  volume;
    logic [2:0]             env_cnt;

    // 2048 - freq, wraps to 0 for freq 0
    assign reload = `APU_FREQ_W'((1 << `APU_FREQ_W) - ctl.freq);

    always_comb begin
        case (ctl.duty)
            2'd0:    pattern = 8'b0000_0001;
            2'd1:    pattern = 8'b0000_0011;
            2'd2:    pattern = 8'b0000_1111;
            default: pattern = 8'b0011_1111;
        endcase
    end

    // duty sequencer
    always_ff @(posedge clk_100) begin
        if (reset) begin
            timer <= '0;
            step  <= '0;
        end else if (ctl.trigger) begin
            timer <= reload;
            step  <= '0;
        end else if (tick_psg) begin
            if (timer == `APU_FREQ_W'(1)) begin
                timer <= reload;
                step  <= step + 3'd1;
            end else begin
                timer <= timer - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_100) begin
        if (reset) begin
            ctl.active <= 1'b0;
            len_cnt    <= '0;
        end else if (ctl.trigger) begin
            ctl.active <= 1'b1;
            len_cnt    <= 7'd64 - 7'(ctl.length);
        end else if (length_clk && ctl.len_en && len_cnt != '0) begin
            len_cnt <= len_cnt - 7'd1;
            if (len_cnt == 7'd1) begin
                ctl.active <= 1'b0;
            end
        end
    end

    // envelope, saturates at 0 and 15
    always_ff @(posedge clk_100) begin
        if (reset) begin
            volume  <= '0;
            env_cnt <= '0;
        end else if (ctl.trigger) begin
            volume  <= ctl.init_vol;
            env_cnt <= '0;
        end else if (env_clk && ctl.env_period != '0) begin
            if (env_cnt >= ctl.env_period - 3'd1) begin
                env_cnt <= '0;
                if (ctl.env_dir == ENV_UP && volume != '1) begin
                    volume <= volume + 1'b1;
                end else if (ctl.env_dir == ENV_DOWN && volume != '0) begin
                    volume <= volume - 1'b1;
                end
            end else begin
                env_cnt <= env_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk_100) begin
        if (reset) begin
            level <= '0;
        end else begin
            level <= (ctl.active && pattern[step]) ? volume : '0;
        end
    end

    a_silent_idle: assert property (@(posedge clk_100) disable iff (reset)
        !$past(ctl.active) |-> level == '0);

endmodule

/* hw/noise_channel.sv */
`timescale 1ns/1ps
`include "apu_cfg.svh"

module noise_channel (
    input  logic                  clk_100,
    input  logic                  reset,
    input  logic                  tick_psg,
    input  logic                  length_clk,
    input  logic                  env_clk,
    chan_ctl_if.chan              ctl,
    output logic [`APU_VOL_W-1:0] level
);
    import apu_pkg::*;

    logic [14:0]           lfsr;
    logic [14:0]           lfsr_next;
    logic                  fb;
    logic [18:0]           period;
    logic [18:0]           div_cnt;
    logic [6:0]            len_cnt;
    logic [`APU_VOL_W-1:0] volume;
    logic [2:0]            env_cnt;

    assign fb     = lfsr[0] ^ lfsr[1];
    // (code + 1) << shift tick_psg pulses per shift
    assign period = (19'(ctl.freq[2:0]) + 19'd1) << ctl.freq[7:4];

    always_comb begin
        lfsr_next = {fb, lfsr[14:1]};
        // short width mode
        if (ctl.freq[3]) begin
            lfsr_next[6] = fb;
        end
    end

    always_ff @(posedge clk_100) begin
        if (reset) begin
            lfsr    <= '1;
            div_cnt <= '0;
        end else if (ctl.trigger) begin
            lfsr    <= '1;
            div_cnt <= '0;
        end else if (tick_psg) begin
            if (div_cnt >= period - 19'd1) begin
                lfsr    <= lfsr_next;
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 19'd1;
            end
        end
    end

    always_ff @(posedge clk_100) begin
        if (reset) begin
            ctl.active <= 1'b0;
            len_cnt    <= '0;
            volume     <= '0;
            env_cnt    <= '0;
        end else if (ctl.trigger) begin
            ctl.active <= 1'b1;
            len_cnt    <= 7'd64 - 7'(ctl.length);
            volume     <= ctl.init_vol;
            env_cnt    <= '0;
        end else begin
            if (length_clk && ctl.len_en && len_cnt != '0) begin
                len_cnt <= len_cnt - 7'd1;
                if (len_cnt == 7'd1) begin
                    ctl.active <= 1'b0;
                end
            end
            if (env_clk && ctl.env_period != '0) begin
                if (env_cnt >= ctl.env_period - 3'd1) begin
                    env_cnt <= '0;
                    if (ctl.env_dir == ENV_UP && volume != '1) begin
                        volume <= volume + 1'b1;
                    end else if (ctl.env_dir == ENV_DOWN && volume != '0) begin
                        volume <= volume - 1'b1;
                    end
                end else begin
                    env_cnt <= env_cnt + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clk_100) begin
        if (reset) begin
            level <= '0;
        end else begin
            level <= (ctl.active && !lfsr[0]) ? volume : '0;
        end
    end

endmodule

/* hw/stereo_mixer.sv */
`timescale 1ns/1ps
`include "apu_cfg.svh"

module stereo_mixer (
    input  logic [`APU_VOL_W-1:0]    levels [`APU_NUM_CH],
    input  logic [2:0]               pan_l,
    input  logic [2:0]               pan_r,
    input  logic [2:0]               vol_l,
    input  logic [2:0]               vol_r,
    output logic [`APU_SAMPLE_W-1:0] mix_l,
    output logic [`APU_SAMPLE_W-1:0] mix_r
);

    localparam int PROD_W = `APU_SAMPLE_W - `APU_MIX_SHIFT;

    logic [5:0]        sum_l;
    logic [5:0]        sum_r;
    logic [PROD_W-1:0] prod_l;
    logic [PROD_W-1:0] prod_r;

    // sum of enabled levels per side
    always_comb begin
        sum_l = '0;
        sum_r = '0;
        for (int i = 0; i < `APU_NUM_CH; i++) begin
            if (pan_l[i]) begin
                sum_l = sum_l + 6'(levels[i]);
            end
            if (pan_r[i]) begin
                sum_r = sum_r + 6'(levels[i]);
            end
        end
    end

    // master volume scales by vol + 1
    assign prod_l = sum_l * ({1'b0, vol_l} + 4'd1);
    assign prod_r = sum_r * ({1'b0, vol_r} + 4'd1);

    assign mix_l = {prod_l, {`APU_MIX_SHIFT{1'b0}}};
    assign mix_r = {prod_r, {`APU_MIX_SHIFT{1'b0}}};

endmodule

/* hw/apu_top.sv */
`timescale 1ns/1ps
`include "apu_cfg.svh"

module apu_top (
    input  logic                     clk_100,
    input  logic                     reset,
    input  logic                     tick_psg,
    input  logic                     tick_256,
    input  logic                     sample_tick,
    input  logic                     saw_mode,
    input  logic                     reg_we,
    input  logic [2:0]               reg_addr,
    input  logic [15:0]              reg_wdata,
    output logic [`APU_SAMPLE_W-1:0] sample_l,
    output logic [`APU_SAMPLE_W-1:0] sample_r,
    output logic                     sample_valid,
    output logic [`APU_NUM_CH-1:0]   chan_active
);
    import apu_pkg::*;

    logic                     power_on;
    logic                     chan_reset;
    logic                     length_clk;
    logic                     env_clk;
    logic [2:0]               pan_l;
    logic [2:0]               pan_r;
    logic [2:0]               vol_l;
    logic [2:0]               vol_r;
    logic [`APU_VOL_W-1:0]    levels [`APU_NUM_CH];
    logic [`APU_SAMPLE_W-1:0] mix_l;
    logic [`APU_SAMPLE_W-1:0] mix_r;
    logic [`APU_SAMPLE_W-1:0] saw_sample;
    logic [5:0]               saw_cnt;

    chan_ctl_if sq1_if ();
    chan_ctl_if sq2_if ();
    chan_ctl_if nz_if ();

    // channels held idle while powered down
    assign chan_reset  = reset || !power_on;
    assign chan_active = {nz_if.active, sq2_if.active, sq1_if.active};

    apu_control ctl0 (
        .clk_100, .reset, .reg_we, .reg_addr(apu_reg_e'(reg_addr)), .reg_wdata, .tick_256,
        .sq1(sq1_if), .sq2(sq2_if), .nz(nz_if), .power_on, .length_clk, .env_clk,
        .pan_l, .pan_r, .vol_l, .vol_r
    );

    tone_channel sq1 (
        .clk_100, .reset(chan_reset), .tick_psg, .length_clk, .env_clk,
        .ctl(sq1_if), .level(levels[0])
    );

    tone_channel sq2 (
        .clk_100, .reset(chan_reset), .tick_psg, .length_clk, .env_clk,
        .ctl(sq2_if), .level(levels[1])
    );

    noise_channel nz (
        .clk_100, .reset(chan_reset), .tick_psg, .length_clk, .env_clk,
        .ctl(nz_if), .level(levels[2])
    );

    stereo_mixer mix0 (.levels, .pan_l, .pan_r, .vol_l, .vol_r, .mix_l, .mix_r);

    assign saw_sample = {saw_cnt, {(`APU_SAMPLE_W - 6){1'b0}}};

    always_ff @(posedge clk_100) begin
        if (reset) begin
            sample_valid <= 1'b0;
            saw_cnt      <= '0;
        end else begin
            sample_valid <= sample_tick;
            if (sample_tick && saw_mode) begin
                saw_cnt <= saw_cnt + 6'd1;
            end
        end
    end

    // output sample register
    always_ff @(posedge clk_100) begin
        if (sample_tick) begin
            sample_l <= saw_mode ? saw_sample : mix_l;
            sample_r <= saw_mode ? saw_sample : mix_r;
        end
    end

    a_valid_single: assert property (@(posedge clk_100) disable iff (reset)
        sample_valid |=> !sample_valid);

endmodule

/* dv/apu_checker.sv */
`timescale 1ns/1ps
`include "apu_cfg.svh"

module apu_checker (
    input logic        clk_100,
    input logic        reset,
    input logic        tick_psg,
    input logic        tick_256,
    input logic        sample_tick,
    input logic        saw_mode,
    input logic        reg_we,
    input logic [2:0]  reg_addr,
    input logic [15:0] reg_wdata,
    input logic [15:0] sample_l,
    input logic [15:0] sample_r,
    input logic        sample_valid,
    input logic [2:0]  chan_active
);
    import apu_pkg::*;

    int errors = 0;
    int checks = 0;

    // reference state, channel 0 sq1, 1 sq2, 2 noise
    logic [15:0] regs [8];
    logic [2:0]  trig_pend;
    logic [2:0]  trig;
    logic        len_strobe;
    logic        env_strobe;
    int          seq_div;
    logic [2:0]  active;
    int          len_left [3];
    int          vol [3];
    int          env_cnt [3];
    int          level [3];
    int          timer [2];
    int          step [2];
    logic [14:0] lfsr;
    int          noise_cnt;
    logic [15:0] exp_l;
    logic [15:0] exp_r;
    logic        exp_valid;
    int          saw;

    // high steps per 8-step duty cycle
    function automatic int duty_len(input logic [1:0] duty);
        case (duty)
            2'd0:    return 1;
            2'd1:    return 2;
            2'd2:    return 4;
            default: return 6;
        endcase
    endfunction

    function automatic logic [15:0] side_mix(input logic [2:0] pan, input logic [2:0] vol_code);
        int sum;
        sum = 0;
        for (int c = 0; c < 3; c++) begin
            if (pan[c]) begin
                sum += level[c];
            end
        end
        return 16'((sum * (int'(vol_code) + 1)) << `APU_MIX_SHIFT);
    endfunction

    task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic reset_channels();
        for (int c = 0; c < 3; c++) begin
            active[c]   = 1'b0;
            len_left[c] = 0;
            vol[c]      = 0;
            env_cnt[c]  = 0;
            level[c]    = 0;
        end
        timer     = '{0, 0};
        step      = '{0, 0};
        lfsr      = '1;
        noise_cnt = 0;
    endtask

    task automatic trigger_load(input int c);
        active[c]   = 1'b1;
        len_left[c] = 64 - int'(regs[2*c][13:8]);
        vol[c]      = int'(regs[2*c][7:4]);
        env_cnt[c]  = 0;
    endtask

    // length counter and envelope, shared by all three channels
    task automatic len_env(input int c);
        logic [15:0] ctl;
        int          period;
        ctl    = regs[2*c];
        period = int'(ctl[2:0]);
        if (len_strobe && regs[2*c+1][14] && len_left[c] > 0) begin
            len_left[c]--;
            if (len_left[c] == 0) begin
                active[c] = 1'b0;
            end
        end
        if (env_strobe && period != 0) begin
            env_cnt[c]++;
            if (env_cnt[c] >= period) begin
                env_cnt[c] = 0;
                if (env_dir_e'(ctl[3]) == ENV_UP) begin
                    vol[c] = (vol[c] < 15) ? vol[c] + 1 : 15;
                end else begin
                    vol[c] = (vol[c] > 0) ? vol[c] - 1 : 0;
                end
            end
        end
    endtask

    always @(posedge clk_100) begin
        logic pwr;
        logic wr_ok;
        int   new_level;
        int   reload;
        int   period;
        logic fb;
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] = '0;
            end
            trig_pend  = '0;
            trig       = '0;
            len_strobe = 1'b0;
            env_strobe = 1'b0;
            seq_div    = 0;
            exp_valid  = 1'b0;
            saw        = 0;
            reset_channels();
        end else begin
            // compare against state from the previous edge
            compare("sample_valid", 16'(exp_valid), 16'(sample_valid));
            if (exp_valid) begin
                compare("sample_l", exp_l, sample_l);
                compare("sample_r", exp_r, sample_r);
                compare("chan_active", 16'(active), 16'(chan_active));
            end

            pwr = regs[REG_POWER][7];
            if (sample_tick) begin
                if (saw_mode) begin
                    exp_l = 16'(saw << 10);
                    exp_r = exp_l;
                    saw   = (saw + 1) % 64;
                end else begin
                    exp_l = side_mix(regs[REG_MASTER][6:4], regs[REG_MASTER][14:12]);
                    exp_r = side_mix(regs[REG_MASTER][2:0], regs[REG_MASTER][10:8]);
                end
            end
            exp_valid = sample_tick;

            if (!pwr) begin
                reset_channels();
            end else begin
                for (int c = 0; c < 2; c++) begin
                    new_level = (active[c] && step[c] < duty_len(regs[2*c][15:14])) ? vol[c] : 0;
                    reload    = 2048 - int'(regs[2*c+1][10:0]);
                    if (trig[c]) begin
                        trigger_load(c);
                        timer[c] = reload;
                        step[c]  = 0;
                    end else begin
                        if (tick_psg) begin
                            timer[c] = (timer[c] + 2047) % 2048;
                            if (timer[c] == 0) begin
                                timer[c] = reload;
                                step[c]  = (step[c] + 1) % 8;
                            end
                        end
                        len_env(c);
                    end
                    level[c] = new_level;
                end
                new_level = (active[2] && !lfsr[0]) ? vol[2] : 0;
                if (trig[2]) begin
                    trigger_load(2);
                    lfsr      = '1;
                    noise_cnt = 0;
                end else begin
                    if (tick_psg) begin
                        period = (int'(regs[REG_NOISE_FREQ][2:0]) + 1) << regs[REG_NOISE_FREQ][7:4];
                        noise_cnt++;
                        if (noise_cnt >= period) begin
                            noise_cnt = 0;
                            fb        = lfsr[0] ^ lfsr[1];
                            lfsr      = {fb, lfsr[14:1]};
                            if (regs[REG_NOISE_FREQ][3]) begin
                                lfsr[6] = fb;
                            end
                        end
                    end
                    len_env(2);
                end
                level[2] = new_level;
            end

            // register file, trigger delay and frame sequencer
            wr_ok        = reg_we && (pwr || reg_addr == REG_POWER);
            trig         = trig_pend;
            trig_pend[0] = wr_ok && reg_wdata[15] && reg_addr == REG_SQ1_FREQ;
            trig_pend[1] = wr_ok && reg_wdata[15] && reg_addr == REG_SQ2_FREQ;
            trig_pend[2] = wr_ok && reg_wdata[15] && reg_addr == REG_NOISE_FREQ;
            len_strobe   = tick_256;
            env_strobe   = tick_256 && seq_div == `APU_ENV_DIV - 1;
            if (tick_256) begin
                seq_div = (seq_div + 1) % `APU_ENV_DIV;
            end
            if (!pwr) begin
                for (int i = 0; i < 7; i++) begin
                    regs[i] = '0;
                end
            end
            if (wr_ok) begin
                if (reg_addr inside {REG_SQ1_FREQ, REG_SQ2_FREQ, REG_NOISE_FREQ}) begin
                    regs[reg_addr] = {1'b0, reg_wdata[14:0]};
                end else begin
                    regs[reg_addr] = reg_wdata;
                end
            end
        end
    end

endmodule

/* dv/tb_apu.sv */
`timescale 1ns/1ps

module tb_apu;
    import apu_pkg::*;

    localparam int PH_IDLE    = 300;
    localparam int PH_SAW     = 80 * 20;
    localparam int PH_TONE    = 6000;
    localparam int PH_NOISE   = 2 * 2500;
    localparam int PH_MIX     = 8 * 200;
    localparam int PH_LEN     = 3400;
    localparam int TOTAL      = 8 + PH_IDLE + PH_SAW + PH_TONE + PH_NOISE + PH_MIX + PH_LEN + 64;
    localparam int TIMEOUT_NS = TOTAL * 15;

    logic        clk_100;
    logic        reset;
    logic        tick_psg;
    logic        tick_256;
    logic        sample_tick;
    logic        saw_mode;
    logic        reg_we;
    logic [2:0]  reg_addr;
    logic [15:0] reg_wdata;
    logic [15:0] sample_l;
    logic [15:0] sample_r;
    logic        sample_valid;
    logic [2:0]  chan_active;

    logic [31:0] lfsr_state = 32'heafd_8045;
    int          cyc = 0;
    int          psg_wait = 2;

    apu_top dut0 (.*);

    apu_checker chk0 (.*);

    always #5 clk_100 = ~clk_100;

    // taps 32 22 2 1
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[14:0], fb};
        end
        return r;
    endfunction

    task automatic next_cycle();
        @(posedge clk_100);
        #1;
        reg_we = 1'b0;
        cyc++;
        psg_wait--;
        tick_psg = (psg_wait == 0);
        if (psg_wait == 0) begin
            psg_wait = 2 + int'(rand_bits(2));
        end
        tick_256    = (cyc % 40 == 0);
        sample_tick = (cyc % 20 == 0);
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic write_reg(input apu_reg_e addr, input logic [15:0] data);
        next_cycle();
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
    endtask

    // short envelope period so saturation shows up within the phase
    task automatic start_tone(input apu_reg_e ctl_reg, input apu_reg_e freq_reg);
        logic [15:0] ctl;
        logic [15:0] fr;
        ctl      = rand_bits(16);
        ctl[2:0] = 3'(1 + int'(rand_bits(1)));
        fr       = {2'b10, 3'b000, 11'h7c0 | 11'(rand_bits(6))};
        write_reg(ctl_reg, ctl);
        write_reg(freq_reg, fr);
    endtask

    task automatic start_noise(input logic short_mode);
        logic [15:0] ctl;
        logic [15:0] fr;
        ctl      = rand_bits(16);
        ctl[2:0] = 3'(rand_bits(2));
        fr       = 16'h8000;
        fr[2:0]  = 3'(rand_bits(3));
        fr[5:4]  = 2'(rand_bits(2));
        fr[3]    = short_mode;
        write_reg(REG_NOISE_CTL, ctl);
        write_reg(REG_NOISE_FREQ, fr);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, stimulus did not complete", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [15:0] w;
        clk_100     = 1'b0;
        reset       = 1'b1;
        tick_psg    = 1'b0;
        tick_256    = 1'b0;
        sample_tick = 1'b0;
        saw_mode    = 1'b0;
        reg_we      = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        repeat (8) @(posedge clk_100);
        #1;
        reset = 1'b0;

        // writes while powered down are dropped
        idle(PH_IDLE - 2);
        write_reg(REG_MASTER, 16'h7777);
        write_reg(REG_SQ1_FREQ, 16'hc7f0);

        next_cycle();
        saw_mode = 1'b1;
        idle((65 + int'(rand_bits(4))) * 20);
        saw_mode = 1'b0;

        // both tones on both sides
        write_reg(REG_POWER, 16'h0080);
        w = (rand_bits(16) & 16'h7700) | 16'h0077;
        write_reg(REG_MASTER, w);
        start_tone(REG_SQ1_CTL, REG_SQ1_FREQ);
        start_tone(REG_SQ2_CTL, REG_SQ2_FREQ);
        idle(PH_TONE);

        start_noise(1'b0);
        idle(PH_NOISE / 2);
        start_noise(1'b1);
        idle(PH_NOISE / 2);

        // full noise volume keeps the pan sums away from zero
        write_reg(REG_NOISE_CTL, 16'h00f0);
        write_reg(REG_NOISE_FREQ, 16'h8000);
        repeat (8) begin
            write_reg(REG_MASTER, rand_bits(16));
            idle(PH_MIX / 8);
        end

        // length counters and a power cycle
        write_reg(REG_MASTER, 16'h7777);
        write_reg(REG_SQ1_CTL, rand_bits(16));
        write_reg(REG_SQ1_FREQ, 16'hc7e0);
        write_reg(REG_NOISE_FREQ, 16'hc011);
        idle(2700);
        write_reg(REG_POWER, 16'h0000);
        idle(60);
        write_reg(REG_MASTER, 16'h7777);
        idle(200);
        // a trigger dropped right before power-on leaves sq2 idle
        write_reg(REG_SQ2_FREQ, 16'hc7f0);
        write_reg(REG_POWER, 16'h0080);
        write_reg(REG_MASTER, 16'h7777);
        idle(40);
        start_tone(REG_SQ2_CTL, REG_SQ2_FREQ);
        idle(300);

        if (chk0.checks == 0) begin
            $display("no samples were compared");
        end
        $display("errors %0d, checks %0d", chk0.errors, chk0.checks);
        if (chk0.errors == 0 && chk0.checks > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+hw
hw/apu_pkg.sv
hw/chan_ctl_if.sv
hw/apu_control.sv
hw/tone_channel.sv
hw/noise_channel.sv
hw/stereo_mixer.sv
hw/apu_top.sv
dv/apu_checker.sv
dv/tb_apu.sv

/* Makefile */
# Verilator build and run of the sound unit testbench

VERILATOR ?= verilator
TOP       ?= tb_apu
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
